// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)

sim: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+common
common/exec_pkg.sv
hdl/alu.sv
mul_unit/mul_unit.sv
hdl/branch_cmp.sv
hdl/exec.sv
tests/tb_clock.sv
tests/exec_sva.sv
tests/exec_tb.sv

// ==== common/exec_consts.svh ====
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// data word
`define LEN_WORD 32

// physical register number
`define LEN_PREG_ADDR 6

// speculation context tag
`define LEN_CONTEXT 4

// one shift-add step per multiplier bit
`define MUL_STEPS 32

`endif

// ==== common/exec_pkg.sv ====
`default_nettype none

`include "exec_consts.svh"

package exec_pkg;

    typedef logic [`LEN_WORD-1:0]      word_t;
    typedef logic [`LEN_PREG_ADDR-1:0] preg_addr_t;
    typedef logic [`LEN_CONTEXT-1:0]   context_t;
    typedef logic [2:0]                func3_t;
    typedef logic [6:0]                func7_t;

    // unit selection from the decoder
    typedef enum logic [2:0] {
        EXEC_NONE,
        EXEC_ALU,
        EXEC_MUL,
        EXEC_BRANCH,
        EXEC_JUMP,
        EXEC_SUBST
    } exec_type_t;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } mul_state_t;

    // to register manager
    typedef struct packed {
        logic       valid;
        preg_addr_t pa_rd;
        word_t      data;
    } write_d_r_t;

    // to context manager
    typedef struct packed {
        logic     ready;
        context_t contex;
        word_t    next_pc;
    } jump_rep_t;

    typedef struct packed {
        logic     hazard;
        context_t contex;
        context_t hazard_context;
        context_t safe_context;
    } branch_rep_t;

endpackage

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             order,
    output logic                  accepted,
    output logic                  done,
    input  wire exec_pkg::func3_t func3,
    input  wire exec_pkg::func7_t func7,
    input  wire exec_pkg::word_t  a,
    input  wire exec_pkg::word_t  b,
    output exec_pkg::word_t       result
);

    exec_pkg::word_t calc;
    logic [4:0]      shamt;
    logic            alt;

    // single cycle, never stalls
    assign accepted = order;

    assign shamt = b[4:0];
    // sub / sra select
    assign alt   = func7[5];

    always_comb begin
        case (func3)
            3'b000: calc = alt ? (a - b) : (a + b);
            3'b001: calc = a << shamt;
            3'b010: calc = {31'b0, $signed(a) < $signed(b)};
            3'b011: calc = {31'b0, a < b};
            3'b100: calc = a ^ b;
            3'b101: calc = alt ? exec_pkg::word_t'($signed(a) >>> shamt) : (a >> shamt);
            3'b110: calc = a | b;
            default: calc = a & b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= order;
        end
    end

    always_ff @(posedge clk) begin
        if (order) begin
            result <= calc;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/branch_cmp.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_cmp (
    input  wire exec_pkg::func3_t func3,
    input  wire exec_pkg::word_t  a,
    input  wire exec_pkg::word_t  b,
    output logic                  taken
);

    always_comb begin
        case (func3)
            3'b000: taken = (a == b);
            3'b001: taken = (a != b);
            3'b100: taken = ($signed(a) < $signed(b));
            3'b101: taken = ($signed(a) >= $signed(b));
            3'b110: taken = (a < b);
            3'b111: taken = (a >= b);
            // 010 and 011 are not branches
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec (
    input  wire logic                 clk,
    input  wire logic                 rst_n,

    // instruction window
    input  wire logic                 order,
    output logic                      accepted,
    input  wire exec_pkg::exec_type_t exec_type,
    input  wire exec_pkg::func3_t     func3,
    input  wire exec_pkg::func7_t     func7,
    input  wire exec_pkg::preg_addr_t pa_rd_in,
    input  wire exec_pkg::word_t      d_rs1,
    input  wire exec_pkg::word_t      d_rs2,
    input  wire exec_pkg::context_t   contex,
    input  wire exec_pkg::context_t   b_t_context,
    input  wire exec_pkg::context_t   b_f_context,

    // register manager
    output exec_pkg::write_d_r_t      write_d_r,

    // context manager
    output exec_pkg::jump_rep_t       jump_rep,
    output exec_pkg::branch_rep_t     branch_rep
);

    logic                 busy;
    logic                 done;
    logic                 order_able;
    exec_pkg::preg_addr_t pa_rd_buf;

    logic            alu_order, alu_accepted, alu_done;
    exec_pkg::word_t alu_rd;
    logic            mul_order, mul_accepted, mul_done;
    exec_pkg::word_t mul_rd;
    logic            jump_order, branch_order, subst_order;
    logic            branch_taken;

    assign order_able = order && !busy;

    assign alu_order    = order_able && (exec_type == exec_pkg::EXEC_ALU);
    assign mul_order    = order_able && (exec_type == exec_pkg::EXEC_MUL);
    assign branch_order = order_able && (exec_type == exec_pkg::EXEC_BRANCH);
    assign jump_order   = order_able && (exec_type == exec_pkg::EXEC_JUMP);
    assign subst_order  = order_able && (exec_type == exec_pkg::EXEC_SUBST);

    alu u_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .order    (alu_order),
        .accepted (alu_accepted),
        .done     (alu_done),
        .func3    (func3),
        .func7    (func7),
        .a        (d_rs1),
        .b        (d_rs2),
        .result   (alu_rd)
    );

    mul_unit u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .order    (mul_order),
        .accepted (mul_accepted),
        .done     (mul_done),
        .func3    (func3),
        .a        (d_rs1),
        .b        (d_rs2),
        .result   (mul_rd)
    );

    branch_cmp u_branch (
        .func3 (func3),
        .a     (d_rs1),
        .b     (d_rs2),
        .taken (branch_taken)
    );

    // jump, branch and subst take and finish in one cycle
    assign accepted = alu_accepted | mul_accepted | jump_order | branch_order | subst_order;
    assign done     = alu_done | mul_done | jump_order | branch_order | subst_order;

    // held from acceptance until the unit reports done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else begin
            busy <= !done && (busy || accepted);
        end
    end

    always_ff @(posedge clk) begin
        if (accepted) begin
            pa_rd_buf <= pa_rd_in;
        end
    end

    always_comb begin
        write_d_r.valid = alu_done | mul_done | jump_order | subst_order;
        // same-cycle finish has no captured address yet
        write_d_r.pa_rd = accepted ? pa_rd_in : pa_rd_buf;
        if (alu_done) begin
            write_d_r.data = alu_rd;
        end else if (mul_done) begin
            write_d_r.data = mul_rd;
        end else if (jump_order) begin
            write_d_r.data = d_rs2;
        end else if (subst_order) begin
            write_d_r.data = d_rs1;
        end else begin
            write_d_r.data = '0;
        end
    end

    always_comb begin
        jump_rep.ready   = jump_order;
        jump_rep.contex  = contex;
        jump_rep.next_pc = d_rs1;
    end

    // taken path becomes the safe one
    always_comb begin
        branch_rep.hazard         = branch_order;
        branch_rep.contex         = contex;
        branch_rep.hazard_context = branch_taken ? b_f_context : b_t_context;
        branch_rep.safe_context   = branch_taken ? b_t_context : b_f_context;
    end

endmodule

`default_nettype wire

// ==== mul_unit/mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module mul_unit (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             order,
    output logic                  accepted,
    output logic                  done,
    input  wire exec_pkg::func3_t func3,
    input  wire exec_pkg::word_t  a,
    input  wire exec_pkg::word_t  b,
    output exec_pkg::word_t       result
);

    localparam int CNT_W = $clog2(`MUL_STEPS);

    exec_pkg::mul_state_t state;
    logic [CNT_W-1:0]     step;
    logic [63:0]          mcand;
    exec_pkg::word_t      mplier;
    logic [63:0]          product;
    logic                 want_hi;

    assign accepted = order && (state == exec_pkg::MUL_IDLE);
    assign done     = (state == exec_pkg::MUL_DONE);
    // mulhu gives the upper word
    assign result   = want_hi ? product[63:32] : product[31:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= exec_pkg::MUL_IDLE;
            step  <= '0;
        end else begin
            case (state)
                exec_pkg::MUL_IDLE: begin
                    if (accepted) begin
                        state <= exec_pkg::MUL_RUN;
                        step  <= '0;
                    end
                end
                exec_pkg::MUL_RUN: begin
                    if (step == CNT_W'(`MUL_STEPS - 1)) begin
                        state <= exec_pkg::MUL_DONE;
                    end
                    step <= step + 1'b1;
                end
                default: begin
                    state <= exec_pkg::MUL_IDLE;
                end
            endcase
        end
    end

    // operand and product datapath
    always_ff @(posedge clk) begin
        if (accepted) begin
            mcand   <= {32'b0, a};
            mplier  <= b;
            product <= '0;
            want_hi <= (func3 == 3'b011);
        end else if (state == exec_pkg::MUL_RUN) begin
            if (mplier[0]) begin
                product <= product + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== tests/exec_patterns.txt ====
// type func3 func7 pa_rd rs1 rs2 context b_t_context b_f_context expected taken
// type 1 alu, 2 mul, 3 branch, 4 jump, 5 subst; expected is the write data or next_pc
1 0 00 05 00000007 00000005 0 0 0 0000000c 0
1 0 20 06 00000003 00000005 0 0 0 fffffffe 0
1 1 00 07 000000f0 00000004 0 0 0 00000f00 0
1 2 00 08 ffffffff 00000001 0 0 0 00000001 0
1 3 00 09 ffffffff 00000001 0 0 0 00000000 0
1 4 00 0a 0f0f0f0f 00ff00ff 0 0 0 0ff00ff0 0
1 5 00 0b 80000000 00000004 0 0 0 08000000 0
1 5 20 0c 80000000 00000004 0 0 0 f8000000 0
1 6 00 0d 12340000 00005678 0 0 0 12345678 0
1 7 00 0e ffff0000 12345678 0 0 0 12340000 0
2 0 01 10 00001234 00005678 0 0 0 06260060 0
2 3 01 11 ffffffff ffffffff 0 0 0 fffffffe 0
2 0 01 12 80000001 00000003 0 0 0 80000003 0
3 0 00 00 00000005 00000005 1 2 3 00000000 1
3 1 00 00 00000007 00000007 4 5 6 00000000 0
3 4 00 00 00000005 ffffffff 7 8 9 00000000 0
3 6 00 00 00000005 ffffffff a b c 00000000 1
3 5 00 00 ffffffff ffffffff d e f 00000000 1
4 0 00 1a 00001000 00000124 3 0 0 00001000 0
5 0 00 1b cafef00d 00000000 0 0 0 cafef00d 0

// ==== tests/exec_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module exec_sva (
    input wire logic                  clk,
    input wire logic                  rst_n,
    input wire logic                  order,
    input wire logic                  accepted,
    input wire logic                  busy,
    input wire logic                  mul_accepted,
    input wire exec_pkg::write_d_r_t  write_d_r,
    input wire exec_pkg::branch_rep_t branch_rep
);

    int fail_count = 0;

    a_accept_needs_order: assert property (
        @(posedge clk) disable iff (!rst_n) accepted |-> order
    ) else begin
        $error("accepted high without an order");
        fail_count++;
    end

    a_accept_not_busy: assert property (
        @(posedge clk) disable iff (!rst_n) accepted |-> !busy
    ) else begin
        $error("accepted high while the stage is busy");
        fail_count++;
    end

    // a branch never writes back
    a_write_or_hazard: assert property (
        @(posedge clk) disable iff (!rst_n) !(write_d_r.valid && branch_rep.hazard)
    ) else begin
        $error("write-back and branch hazard in the same cycle");
        fail_count++;
    end

    a_mul_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        mul_accepted |-> ##(`MUL_STEPS + 1) write_d_r.valid
    ) else begin
        $error("multiply write-back not at the expected cycle");
        fail_count++;
    end

endmodule

bind exec exec_sva u_exec_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .order        (order),
    .accepted     (accepted),
    .busy         (busy),
    .mul_accepted (mul_accepted),
    .write_d_r    (write_d_r),
    .branch_rep   (branch_rep)
);

`default_nettype wire

// ==== tests/exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module exec_tb;

    localparam int FIELDS    = 11;
    localparam int MAX_TESTS = 64;
    localparam int MEM_SIZE  = FIELDS * MAX_TESTS;

    // columns of one record
    localparam int F_TYPE  = 0;
    localparam int F_FUNC3 = 1;
    localparam int F_FUNC7 = 2;
    localparam int F_PA_RD = 3;
    localparam int F_RS1   = 4;
    localparam int F_RS2   = 5;
    localparam int F_CTX   = 6;
    localparam int F_BT    = 7;
    localparam int F_BF    = 8;
    localparam int F_EXP   = 9;
    localparam int F_TAKEN = 10;

    logic                  clk;
    logic                  rst_n;
    logic                  order;
    logic                  accepted;
    exec_pkg::exec_type_t  exec_type;
    exec_pkg::func3_t      func3;
    exec_pkg::func7_t      func7;
    exec_pkg::preg_addr_t  pa_rd_in;
    exec_pkg::word_t       d_rs1;
    exec_pkg::word_t       d_rs2;
    exec_pkg::context_t    ctx;
    exec_pkg::context_t    b_t_context;
    exec_pkg::context_t    b_f_context;
    exec_pkg::write_d_r_t  write_d_r;
    exec_pkg::jump_rep_t   jump_rep;
    exec_pkg::branch_rep_t branch_rep;

    exec_pkg::word_t pat_mem [0:MEM_SIZE-1];

    int num_tests;
    int cycle       = 0;
    int cycle_limit = 0;
    int errors      = 0;
    int test_errors = 0;
    int checks      = 0;
    int acc_cycle   = 0;
    bit next_driven = 1'b0;

    tb_clock #(.PERIOD(10)) u_clock (.clk(clk));

    exec u_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .order       (order),
        .accepted    (accepted),
        .exec_type   (exec_type),
        .func3       (func3),
        .func7       (func7),
        .pa_rd_in    (pa_rd_in),
        .d_rs1       (d_rs1),
        .d_rs2       (d_rs2),
        .contex      (ctx),
        .b_t_context (b_t_context),
        .b_f_context (b_f_context),
        .write_d_r   (write_d_r),
        .jump_rep    (jump_rep),
        .branch_rep  (branch_rep)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle_limit > 0 && cycle >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle);
            $display("Test failed");
            $finish;
        end
    end

    function automatic exec_pkg::word_t rec_field(input int t, input int col);
        return pat_mem[t * FIELDS + col];
    endfunction

    task automatic drive_record(input int t);
        exec_pkg::word_t raw;
        raw       = rec_field(t, F_TYPE);
        exec_type = exec_pkg::exec_type_t'(raw[2:0]);
        raw       = rec_field(t, F_FUNC3);
        func3     = raw[2:0];
        raw       = rec_field(t, F_FUNC7);
        func7     = raw[6:0];
        raw       = rec_field(t, F_PA_RD);
        pa_rd_in  = raw[`LEN_PREG_ADDR-1:0];
        d_rs1     = rec_field(t, F_RS1);
        d_rs2     = rec_field(t, F_RS2);
        raw       = rec_field(t, F_CTX);
        ctx       = raw[`LEN_CONTEXT-1:0];
        raw       = rec_field(t, F_BT);
        b_t_context = raw[`LEN_CONTEXT-1:0];
        raw       = rec_field(t, F_BF);
        b_f_context = raw[`LEN_CONTEXT-1:0];
        order     = 1'b1;
    endtask

    task automatic release_order();
        order     = 1'b0;
        exec_type = exec_pkg::EXEC_NONE;
    endtask

    task automatic check_value(input string name, input exec_pkg::word_t got,
                               input exec_pkg::word_t exp);
        checks++;
        assert (got == exp) else begin
            $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    // wait for the write-back while a held order stays unaccepted
    task automatic wait_write(input bit held, output int latency);
        do begin
            @(negedge clk);
            if (held) begin
                checks++;
                assert (!accepted) else begin
                    $display("error at %0d ns: held order accepted during a multiply", $time);
                    test_errors++;
                end
            end
        end while (!write_d_r.valid);
        latency = cycle - acc_cycle;
    endtask

    task automatic run_test(input int t);
        exec_pkg::exec_type_t kind;
        exec_pkg::word_t      raw;
        exec_pkg::word_t      exp;
        exec_pkg::word_t      pa_exp;
        bit                   taken;
        int                   latency;
        test_errors = 0;
        raw    = rec_field(t, F_TYPE);
        kind   = exec_pkg::exec_type_t'(raw[2:0]);
        exp    = rec_field(t, F_EXP);
        pa_exp = rec_field(t, F_PA_RD);
        raw    = rec_field(t, F_TAKEN);
        taken  = raw[0];
        if (!next_driven) begin
            @(posedge clk);
            #1;
            drive_record(t);
        end
        next_driven = 1'b0;
        do begin
            @(negedge clk);
        end while (!accepted);
        acc_cycle = cycle;
        case (kind)
            exec_pkg::EXEC_ALU: begin
                @(posedge clk);
                #1;
                release_order();
                wait_write(1'b0, latency);
                check_value("alu latency", 32'(latency), 32'd1);
                check_value("write_d_r.pa_rd", 32'(write_d_r.pa_rd), pa_exp);
                check_value("write_d_r.data", write_d_r.data, exp);
            end
            exec_pkg::EXEC_MUL: begin
                @(posedge clk);
                #1;
                // next instruction waits behind the multiply
                if (t + 1 < num_tests) begin
                    drive_record(t + 1);
                    next_driven = 1'b1;
                end else begin
                    release_order();
                end
                wait_write(next_driven, latency);
                check_value("mul latency", 32'(latency), 32'(`MUL_STEPS + 1));
                check_value("write_d_r.pa_rd", 32'(write_d_r.pa_rd), pa_exp);
                check_value("write_d_r.data", write_d_r.data, exp);
            end
            exec_pkg::EXEC_BRANCH: begin
                check_value("branch_rep.hazard", 32'(branch_rep.hazard), 32'd1);
                check_value("write_d_r.valid", 32'(write_d_r.valid), 32'd0);
                check_value("branch_rep.contex", 32'(branch_rep.contex), rec_field(t, F_CTX));
                check_value("branch_rep.safe_context", 32'(branch_rep.safe_context),
                            taken ? rec_field(t, F_BT) : rec_field(t, F_BF));
                check_value("branch_rep.hazard_context", 32'(branch_rep.hazard_context),
                            taken ? rec_field(t, F_BF) : rec_field(t, F_BT));
            end
            exec_pkg::EXEC_JUMP: begin
                check_value("jump_rep.ready", 32'(jump_rep.ready), 32'd1);
                check_value("jump_rep.next_pc", jump_rep.next_pc, exp);
                check_value("jump_rep.contex", 32'(jump_rep.contex), rec_field(t, F_CTX));
                check_value("write_d_r.valid", 32'(write_d_r.valid), 32'd1);
                check_value("write_d_r.pa_rd", 32'(write_d_r.pa_rd), pa_exp);
                check_value("write_d_r.data", write_d_r.data, rec_field(t, F_RS2));
            end
            exec_pkg::EXEC_SUBST: begin
                check_value("write_d_r.valid", 32'(write_d_r.valid), 32'd1);
                check_value("write_d_r.pa_rd", 32'(write_d_r.pa_rd), pa_exp);
                check_value("write_d_r.data", write_d_r.data, exp);
            end
            default: begin
                $display("error at %0d ns: record %0d has an unknown exec type", $time, t);
                test_errors++;
            end
        endcase
        if (kind != exec_pkg::EXEC_ALU && kind != exec_pkg::EXEC_MUL) begin
            @(posedge clk);
            #1;
            release_order();
        end
        errors += test_errors;
        if (test_errors == 0) begin
            $display("test %0d (%s): ok", t, kind.name());
        end else begin
            $display("test %0d (%s): %0d errors", t, kind.name(), test_errors);
        end
    endtask

    initial begin
        int t;
        rst_n       = 1'b0;
        order       = 1'b0;
        exec_type   = exec_pkg::EXEC_NONE;
        func3       = '0;
        func7       = '0;
        pa_rd_in    = '0;
        d_rs1       = '0;
        d_rs2       = '0;
        ctx         = '0;
        b_t_context = '0;
        b_f_context = '0;
        // unused slots read as an invalid exec type
        for (int i = 0; i < MEM_SIZE; i++) begin
            pat_mem[i] = 32'hbad00000 | 32'(i);
        end
        $readmemh("tests/exec_patterns.txt", pat_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && pat_mem[num_tests * FIELDS] <= 32'd5) begin
            num_tests++;
        end
        cycle_limit = num_tests * (`MUL_STEPS + 8) + 50;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        errors += u_exec.u_exec_sva.fail_count;
        $display("tests: %0d, checks: %0d, errors: %0d", num_tests, checks, errors);
        if (errors == 0 && num_tests > 0) begin
            $display("Test completed successfully");
        end else begin
            if (num_tests == 0) begin
                $display("no pattern records could be read");
            end
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire
